// ==== src.f ====
+incdir+include
source/nx_pkg.sv
source/nx_fifo.sv
source/nx_stream_arbiter.sv
source/nx_msg_decoder.sv
source/nx_stream_distributor.sv
source/nx_node_router.sv
bench/tb_nx_node_router.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -f src.f --top-module tb_nx_node_router -o sim_router \
    > build.log 2>&1 \
    && ./obj_dir/sim_router > sim.log 2>&1 \
    ; cat build.log sim.log 2>/dev/null \
    ; [ -s sim.log ] && ! grep -q "Verification failed" sim.log \
    || { echo "Simulation run reported a failure"; exit 1; }

exit 0

// ==== bench/tb_nx_node_router.sv ====
`include "nx_consts.svh"

module tb_nx_node_router;
timeunit 1ns;
timeprecision 100ps;

localparam int MSGS_PER_SRC = 100;
localparam int FAIR_WINDOW  = 64;
// Longest test moves every source's messages once
localparam int WATCHDOG_CYCLES = 40 * MSGS_PER_SRC * `NX_INPUTS;

logic                                       clk = 1'b0;
logic                                       rst_n = 1'b0;
nx_pkg::node_position_t                     position = '0;
nx_pkg::node_position_t                     next_position = '0;
nx_pkg::node_message_t [`NX_INPUTS-1:0]     in_data = '0;
logic [`NX_INPUTS-1:0]                      in_valid = '0;
logic [`NX_INPUTS-1:0]                      in_ready;
nx_pkg::node_message_t [`NX_DIRECTIONS-1:0] out_data;
logic [`NX_DIRECTIONS-1:0]                  out_valid;
logic [`NX_DIRECTIONS-1:0]                  out_ready = '1;
logic                                       idle;

// Stimulus control from the test sequence
string test_name = "reset";
bit    bp_mode = 1'b0;
bit    fair_mode = 1'b0;
int    stuck_dir = 0;
int    gen_cnt [`NX_INPUTS] = '{default: 0};
int    gen_stop [`NX_INPUTS] = '{default: 0};
int    fair_cnt [`NX_INPUTS] = '{default: 0};
int    fair_xfers = 0;
int    drive_cycles = 0;
int    cycle_cnt = 0;
int    test_start = 0;
int    error_cnt = 0;
int    errs_at_start = 0;
int    pass_cnt = 0;
int    fail_cnt = 0;

// Expected traffic with one queue per source and exit
nx_pkg::node_message_t model_q [`NX_INPUTS][`NX_DIRECTIONS][$];
// Outbound words stalled on the previous edge
logic                  held [`NX_DIRECTIONS];
nx_pkg::node_message_t held_data [`NX_DIRECTIONS];

nx_node_router dut_i (
      .i_clk            ( clk       )
    , .i_rst_n          ( rst_n     )
    , .i_position       ( position  )
    , .i_inbound_data   ( in_data   )
    , .i_inbound_valid  ( in_valid  )
    , .o_inbound_ready  ( in_ready  )
    , .o_outbound_data  ( out_data  )
    , .o_outbound_valid ( out_valid )
    , .i_outbound_ready ( out_ready )
    , .o_idle           ( idle      )
);

always #2 clk = ~clk;

// Column decides before row and the own node goes local
function automatic nx_pkg::direction_t expected_exit(nx_pkg::node_header_t hdr);
    if (hdr.target_col > position.col) return nx_pkg::DIR_EAST;
    if (hdr.target_col < position.col) return nx_pkg::DIR_WEST;
    if (hdr.target_row > position.row) return nx_pkg::DIR_SOUTH;
    if (hdr.target_row < position.row) return nx_pkg::DIR_NORTH;
    return nx_pkg::DIR_LOCAL;
endfunction

// Payload is source index over sequence number
function automatic nx_pkg::node_message_t make_message(int src, int seq);
    nx_pkg::node_message_t msg;
    msg.header.target_row = 4'($urandom_range(0, 15));
    msg.header.target_col = 4'($urandom_range(0, 15));
    // About a quarter aimed at this node
    if ($urandom_range(0, 3) == 0) begin
        msg.header.target_row = position.row;
        msg.header.target_col = position.col;
    end
    msg.payload = {4'(src), 20'(seq)};
    return msg;
endfunction

function automatic int model_level();
    int total;
    total = 0;
    for (int s = 0; s < `NX_INPUTS; s++) begin
        for (int d = 0; d < `NX_DIRECTIONS; d++) begin
            total += model_q[s][d].size();
        end
    end
    return total;
endfunction

function automatic bit stim_done();
    for (int s = 0; s < `NX_INPUTS; s++) begin
        if (gen_cnt[s] < gen_stop[s]) return 1'b0;
    end
    return 1'b1;
endfunction

task automatic check_message(string name, nx_pkg::node_message_t exp,
                             nx_pkg::node_message_t act);
    if (exp !== act) begin
        error_cnt++;
        $display("Error in %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_direction(string name, nx_pkg::direction_t exp,
                               nx_pkg::direction_t act);
    if (exp !== act) begin
        error_cnt++;
        $display("Error in %s: expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic check_count(string name, int exp, int act);
    if (exp != act) begin
        error_cnt++;
        $display("Error in %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

// Reset, position and all stimulus change on the rising edge
always @(posedge clk) begin
    rst_n    <= (drive_cycles >= 15);
    position <= next_position;
    if (rst_n) begin
        for (int s = 0; s < `NX_INPUTS; s++) begin
            // Slot frees up when empty or just taken
            if (!in_valid[s] || in_ready[s]) begin
                if (gen_cnt[s] < gen_stop[s] && (fair_mode || $urandom_range(0, 1) == 1)) begin
                    in_data[s]  <= make_message(s, gen_cnt[s]);
                    in_valid[s] <= 1'b1;
                    gen_cnt[s]++;
                end else begin
                    in_valid[s] <= 1'b0;
                end
            end
        end
        // One exit blocked for 48 of every 64 cycles and the rest random
        for (int d = 0; d < `NX_DIRECTIONS; d++) begin
            if (d == stuck_dir) begin
                out_ready[d] <= !bp_mode || ((drive_cycles % 64) >= 48);
            end else begin
                out_ready[d] <= !bp_mode || ($urandom_range(0, 3) != 0);
            end
        end
    end
    drive_cycles++;
end

// Monitor samples pre-edge values like the DUT
always @(posedge clk) begin
    nx_pkg::node_message_t msg;
    int                    src;
    if (rst_n) begin
        for (int s = 0; s < `NX_INPUTS; s++) begin
            if (in_valid[s] && in_ready[s]) begin
                model_q[s][expected_exit(in_data[s].header)].push_back(in_data[s]);
                // Fairness window only while all inputs compete
                if (fair_mode && (&in_valid) && fair_xfers < FAIR_WINDOW) begin
                    fair_cnt[s]++;
                    fair_xfers++;
                end
            end
        end
        for (int d = 0; d < `NX_DIRECTIONS; d++) begin
            if (held[d] && !out_valid[d]) begin
                error_cnt++;
                $display("Test %s: valid on exit %0d dropped while stalled", test_name, d);
            end else if (held[d]) begin
                check_message(test_name, held_data[d], out_data[d]);
            end
            if (out_valid[d] && out_ready[d]) begin
                msg = out_data[d];
                src = int'(msg.payload[23:20]);
                check_direction(test_name, expected_exit(msg.header), nx_pkg::direction_t'(d));
                if (src >= `NX_INPUTS || model_q[src][d].size() == 0) begin
                    error_cnt++;
                    $display("Test %s: unexpected message %h on exit %0d", test_name, msg, d);
                end else begin
                    check_message(test_name, model_q[src][d].pop_front(), msg);
                end
            end
            held[d]      = out_valid[d] && !out_ready[d];
            held_data[d] = out_data[d];
        end
    end
end

// Watchdog restarts with every test
always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt - test_start > WATCHDOG_CYCLES) begin
        $display("Timeout: test %s hung for %0d cycles", test_name, WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end
end

task automatic begin_test(string name);
    test_name     = name;
    test_start    = cycle_cnt;
    errs_at_start = error_cnt;
endtask

task automatic end_test();
    if (error_cnt == errs_at_start) begin
        pass_cnt++;
        $display("Test %s: ok", test_name);
    end else begin
        fail_cnt++;
        $display("Test %s: FAILED with %0d errors", test_name, error_cnt - errs_at_start);
    end
endtask

// New position while idle and then traffic until drained
task automatic run_traffic(int msgs, bit bp, bit fair);
    next_position.row = 4'($urandom_range(0, 15));
    next_position.col = 4'($urandom_range(0, 15));
    repeat (2) @(negedge clk);
    bp_mode   = bp;
    fair_mode = fair;
    stuck_dir = $urandom_range(0, `NX_DIRECTIONS - 1);
    for (int s = 0; s < `NX_INPUTS; s++) begin
        gen_stop[s] = gen_cnt[s] + msgs;
    end
    do @(negedge clk); while (!(stim_done() && in_valid == '0));
    bp_mode   = 1'b0;
    fair_mode = 1'b0;
    do @(negedge clk); while (!idle);
    check_count(test_name, 0, model_level());
endtask

initial begin
    void'($urandom(32'h1191300b));
    begin_test("reset");
    wait (rst_n);
    repeat (2) @(negedge clk);
    check_count(test_name, 0, int'(out_valid));
    check_count(test_name, 1, int'(idle));
    end_test();

    begin_test("routing");
    run_traffic(MSGS_PER_SRC, 1'b0, 1'b0);
    end_test();

    begin_test("backpressure");
    run_traffic(MSGS_PER_SRC, 1'b1, 1'b0);
    end_test();

    // Idle comes back after stalled traffic and then holds
    begin_test("drain");
    run_traffic(MSGS_PER_SRC / 4, 1'b1, 1'b0);
    repeat (32) begin
        @(negedge clk);
        check_count(test_name, 1, int'(idle));
    end
    end_test();

    begin_test("fairness");
    run_traffic(40, 1'b0, 1'b1);
    for (int s = 0; s < `NX_INPUTS; s++) begin
        check_count(test_name, FAIR_WINDOW / `NX_INPUTS, fair_cnt[s]);
    end
    end_test();

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule : tb_nx_node_router

// ==== source/nx_node_router.sv ====
`include "nx_consts.svh"

module nx_node_router (
      input  logic                                         i_clk
    , input  logic                                         i_rst_n
    // Node coordinates, only changed while idle
    , input  nx_pkg::node_position_t                       i_position
    // Directional inbound streams
    , input  nx_pkg::node_message_t [`NX_INPUTS-1:0]     i_inbound_data
    , input  logic [`NX_INPUTS-1:0]                        i_inbound_valid
    , output logic [`NX_INPUTS-1:0]                        o_inbound_ready
    // Outbound streams indexed by direction
    , output nx_pkg::node_message_t [`NX_DIRECTIONS-1:0] o_outbound_data
    , output logic [`NX_DIRECTIONS-1:0]                    o_outbound_valid
    , input  logic [`NX_DIRECTIONS-1:0]                    i_outbound_ready
    // Whole router empty
    , output logic                                         o_idle
);

// Arbiter to decoder
nx_pkg::node_message_t   merged_data;
logic                    merged_valid, merged_ready;

// Decoder to distributor
nx_pkg::routed_message_t routed_data;
logic                    routed_valid, routed_ready;

logic                    dist_idle;

// Merge the four directions
nx_stream_arbiter u_arbiter (
      .i_clk           ( i_clk           )
    , .i_rst_n         ( i_rst_n         )
    , .i_inbound_data  ( i_inbound_data  )
    , .i_inbound_valid ( i_inbound_valid )
    , .o_inbound_ready ( o_inbound_ready )
    , .o_merged_data   ( merged_data     )
    , .o_merged_valid  ( merged_valid    )
    , .i_merged_ready  ( merged_ready    )
);

// Pick the exit
nx_msg_decoder u_decoder (
      .i_clk          ( i_clk        )
    , .i_rst_n        ( i_rst_n      )
    , .i_position     ( i_position   )
    , .i_msg_data     ( merged_data  )
    , .i_msg_valid    ( merged_valid )
    , .o_msg_ready    ( merged_ready )
    , .o_routed_data  ( routed_data  )
    , .o_routed_valid ( routed_valid )
    , .i_routed_ready ( routed_ready )
);

// Fan out to the egress buffers
nx_stream_distributor u_distributor (
      .i_clk            ( i_clk            )
    , .i_rst_n          ( i_rst_n          )
    , .o_idle           ( dist_idle        )
    , .i_inbound_data   ( routed_data      )
    , .i_inbound_valid  ( routed_valid     )
    , .o_inbound_ready  ( routed_ready     )
    , .o_outbound_data  ( o_outbound_data  )
    , .o_outbound_valid ( o_outbound_valid )
    , .i_outbound_ready ( i_outbound_ready )
);

// Idle once every stage is drained and no new input waits
assign o_idle = dist_idle && !routed_valid && !(|i_inbound_valid);

endmodule : nx_node_router

// ==== source/nx_stream_distributor.sv ====
`include "nx_consts.svh"

module nx_stream_distributor (
      input  logic                                         i_clk
    , input  logic                                         i_rst_n
    // High when nothing is buffered or arriving
    , output logic                                         o_idle
    // Routed inbound stream
    , input  nx_pkg::routed_message_t                      i_inbound_data
    , input  logic                                         i_inbound_valid
    , output logic                                         o_inbound_ready
    // One outbound stream per exit
    , output nx_pkg::node_message_t [`NX_DIRECTIONS-1:0] o_outbound_data
    , output logic [`NX_DIRECTIONS-1:0]                    o_outbound_valid
    , input  logic [`NX_DIRECTIONS-1:0]                    i_outbound_ready
);

logic [`NX_DIRECTIONS-1:0] fifo_full, fifo_empty, fifo_match;

for (genvar idx = 0; idx < `NX_DIRECTIONS; idx++) begin : gen_egress
    logic fifo_push, fifo_pop;

    // Direction field selects the egress FIFO
    assign fifo_match[idx] = (i_inbound_data.dir == nx_pkg::direction_t'(idx));
    assign fifo_push = fifo_match[idx] && i_inbound_valid && !fifo_full[idx];
    assign fifo_pop  = !fifo_empty[idx] && i_outbound_ready[idx];

    assign o_outbound_valid[idx] = !fifo_empty[idx];

    nx_fifo #(
          .data_t    ( nx_pkg::node_message_t )
        , .DEPTH     ( `NX_FIFO_DEPTH         )
    ) u_egress_fifo (
          .i_clk     ( i_clk                  )
        , .i_rst_n   ( i_rst_n                )
        , .i_wr_data ( i_inbound_data.message )
        , .i_wr_push ( fifo_push              )
        , .o_rd_data ( o_outbound_data[idx]   )
        , .i_rd_pop  ( fifo_pop               )
        , .o_empty   ( fifo_empty[idx]        )
        , .o_full    ( fifo_full[idx]         )
    );
end

// Stall only on the FIFO being targeted
assign o_inbound_ready = !(|(fifo_full & fifo_match));

// All egress empty and nothing pending
assign o_idle = (&fifo_empty) && !i_inbound_valid;

endmodule : nx_stream_distributor

// ==== source/nx_msg_decoder.sv ====
`include "nx_consts.svh"

module nx_msg_decoder (
      input  logic                    i_clk
    , input  logic                    i_rst_n
    // This node's place in the mesh
    , input  nx_pkg::node_position_t  i_position
    // Merged inbound stream
    , input  nx_pkg::node_message_t   i_msg_data
    , input  logic                    i_msg_valid
    , output logic                    o_msg_ready
    // Routed stream toward the distributor
    , output nx_pkg::routed_message_t o_routed_data
    , output logic                    o_routed_valid
    , input  logic                    i_routed_ready
);

nx_pkg::direction_t      route_dir;
nx_pkg::routed_message_t routed;
logic                    fifo_push, fifo_pop;
logic                    fifo_empty, fifo_full;

// Column first, then row
always_comb begin
    if (i_msg_data.header.target_col > i_position.col) begin
        route_dir = nx_pkg::DIR_EAST;
    end else if (i_msg_data.header.target_col < i_position.col) begin
        route_dir = nx_pkg::DIR_WEST;
    end else if (i_msg_data.header.target_row > i_position.row) begin
        route_dir = nx_pkg::DIR_SOUTH;
    end else if (i_msg_data.header.target_row < i_position.row) begin
        route_dir = nx_pkg::DIR_NORTH;
    end else begin
        // Addressed to this node
        route_dir = nx_pkg::DIR_LOCAL;
    end
end

// Decision travels with the message
assign routed.dir     = route_dir;
assign routed.message = i_msg_data;

assign o_msg_ready = !fifo_full;
assign fifo_push   = i_msg_valid && !fifo_full;
assign fifo_pop    = o_routed_valid && i_routed_ready;

// Head of the FIFO drives the routed stream
assign o_routed_valid = !fifo_empty;

nx_fifo #(
      .data_t    ( nx_pkg::routed_message_t )
    , .DEPTH     ( `NX_FIFO_DEPTH           )
) u_route_fifo (
      .i_clk     ( i_clk                    )
    , .i_rst_n   ( i_rst_n                  )
    , .i_wr_data ( routed                   )
    , .i_wr_push ( fifo_push                )
    , .o_rd_data ( o_routed_data            )
    , .i_rd_pop  ( fifo_pop                 )
    , .o_empty   ( fifo_empty               )
    , .o_full    ( fifo_full                )
);

endmodule : nx_msg_decoder

// ==== source/nx_stream_arbiter.sv ====
`include "nx_consts.svh"

module nx_stream_arbiter (
      input  logic                                     i_clk
    , input  logic                                     i_rst_n
    // Directional inbound streams
    , input  nx_pkg::node_message_t [`NX_INPUTS-1:0] i_inbound_data
    , input  logic [`NX_INPUTS-1:0]                    i_inbound_valid
    , output logic [`NX_INPUTS-1:0]                    o_inbound_ready
    // Merged stream toward the decoder
    , output nx_pkg::node_message_t                    o_merged_data
    , output logic                                     o_merged_valid
    , input  logic                                     i_merged_ready
);

localparam int IDX_W = $clog2(`NX_INPUTS);

// Round-robin pointer, first input to be considered
logic [IDX_W-1:0] rr_ptr;

// Current winner of the search
logic [IDX_W-1:0] winner;
logic             found;
logic             xfer;

// First valid input at or after the pointer
always_comb begin
    int idx;
    found  = 1'b0;
    winner = rr_ptr;
    for (int off = 0; off < `NX_INPUTS; off++) begin
        idx = (int'(rr_ptr) + off) % `NX_INPUTS;
        if (!found && i_inbound_valid[idx]) begin
            found  = 1'b1;
            winner = IDX_W'(idx);
        end
    end
end

// Pass the winner straight through
assign o_merged_valid = found;
assign o_merged_data  = i_inbound_data[winner];

// Only the winning input sees ready
always_comb begin
    for (int i = 0; i < `NX_INPUTS; i++) begin
        o_inbound_ready[i] = found && i_merged_ready && (winner == IDX_W'(i));
    end
end

assign xfer = o_merged_valid && i_merged_ready;

// Move past the winner once its message is taken
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        rr_ptr <= '0;
    end else if (xfer) begin
        if (winner == IDX_W'(`NX_INPUTS - 1)) begin
            rr_ptr <= '0;
        end else begin
            rr_ptr <= winner + 1'b1;
        end
    end
end

endmodule : nx_stream_arbiter

// ==== source/nx_fifo.sv ====
module nx_fifo #(
      parameter type data_t = logic [31:0]
    , parameter int  DEPTH  = 2
) (
      input  logic  i_clk
    , input  logic  i_rst_n
    // Write side
    , input  data_t i_wr_data
    , input  logic  i_wr_push
    // Read side
    , output data_t o_rd_data
    , input  logic  i_rd_pop
    // Status
    , output logic  o_empty
    , output logic  o_full
);

// Pointer and level widths
localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int LVL_W = $clog2(DEPTH + 1);

// Storage, no reset needed
data_t mem [DEPTH];

logic [PTR_W-1:0] wr_ptr, rd_ptr;
logic [LVL_W-1:0] level;
logic             do_push, do_pop;

// Pop only with data present
assign do_pop  = i_rd_pop && !o_empty;
// Push when room, or when a pop frees a slot this cycle
assign do_push = i_wr_push && (!o_full || do_pop);

assign o_empty   = (level == '0);
assign o_full    = (level == LVL_W'(DEPTH));
assign o_rd_data = mem[rd_ptr];

// Write into the slot under the write pointer
always_ff @(posedge i_clk) begin
    if (do_push) begin
        mem[wr_ptr] <= i_wr_data;
    end
end

// Pointers wrap at DEPTH, level tracks occupancy
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        level  <= '0;
    end else begin
        if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        // Simultaneous push and pop leaves level unchanged
        if (do_push && !do_pop) begin
            level <= level + 1'b1;
        end else if (do_pop && !do_push) begin
            level <= level - 1'b1;
        end
    end
end

endmodule : nx_fifo

// ==== source/nx_pkg.sv ====
`include "nx_consts.svh"

package nx_pkg;

    // Address of the node a message is heading for
    typedef struct packed {
        logic [`NX_ROW_WIDTH-1:0] target_row;
        logic [`NX_COL_WIDTH-1:0] target_col;
    } node_header_t;

    // Single-word data message
    typedef struct packed {
        node_header_t              header;
        logic [`NX_DATA_WIDTH-1:0] payload;
    } node_message_t;

    // Exit of this node, also the index of the outbound stream
    typedef enum logic [2:0] {
        DIR_NORTH = 3'd0,
        DIR_EAST  = 3'd1,
        DIR_SOUTH = 3'd2,
        DIR_WEST  = 3'd3,
        DIR_LOCAL = 3'd4
    } direction_t;

    // Message with its route decision attached
    typedef struct packed {
        direction_t    dir;
        node_message_t message;
    } routed_message_t;

    // Where this node sits in the mesh
    typedef struct packed {
        logic [`NX_ROW_WIDTH-1:0] row;
        logic [`NX_COL_WIDTH-1:0] col;
    } node_position_t;

endpackage : nx_pkg

// ==== include/nx_consts.svh ====
`ifndef NX_CONSTS_SVH
`define NX_CONSTS_SVH

// Mesh coordinate widths
`define NX_ROW_WIDTH 4
`define NX_COL_WIDTH 4

// Payload bits carried by a single-word data message
`define NX_DATA_WIDTH 24

// Exits of a node (north, east, south, west, local)
`define NX_DIRECTIONS 5

// Directional inbound streams, local ingress not counted
`define NX_INPUTS 4

// Entries in every egress and decoder FIFO
`define NX_FIFO_DEPTH 2

`endif
